//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mini_warp_tb
FILELIST  = mini_warp.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- mini_warp.f
rtl/warp_pkg.sv
rtl/instr_fetch.sv
rtl/instr_decoder.sv
rtl/decoded_queue.sv
rtl/scalar_exec.sv
rtl/mini_warp_top.sv
verification/tb_clock_gen.sv
verification/mini_warp_tb.sv

//--- rtl/decoded_queue.sv
`default_nettype none

module decoded_queue (
    input wire clk,
    input wire reset,
    input wire push,
    input wire warp_pkg::decoded_op_t push_op,
    input wire pop,
    output warp_pkg::decoded_op_t queue_head,
    output logic queue_empty,
    output logic queue_almost_full
);

    warp_pkg::decoded_op_t entries [warp_pkg::QUEUE_DEPTH];

    logic [warp_pkg::QUEUE_PTR_WIDTH-1:0] wr_ptr;
    logic [warp_pkg::QUEUE_PTR_WIDTH-1:0] rd_ptr;
    logic [warp_pkg::QUEUE_PTR_WIDTH:0] count;

    assign queue_head = entries[rd_ptr];
    assign queue_empty = (count == '0);
    assign queue_almost_full =
        (count >= (warp_pkg::QUEUE_DEPTH - warp_pkg::QUEUE_SLACK));

    // storage, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_op;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the slack upstream has to keep a full queue from ever seeing a push
    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset) !(push && count == warp_pkg::QUEUE_DEPTH)
    ) else $error("push into full queue");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset) !(pop && queue_empty)
    ) else $error("pop from empty queue");

endmodule

`default_nettype wire

//--- rtl/instr_decoder.sv
`default_nettype none

module instr_decoder (
    input wire clk,
    input wire reset,
    input wire fetch_valid,
    input wire warp_pkg::instr_word_u fetch_word,
    output logic dec_valid,
    output warp_pkg::decoded_op_t dec_op
);

    logic [warp_pkg::DATA_WIDTH-1:0] imm_i;
    logic [19:0] imm_u;

    // I immediate, sign-extended from 14 bits
    assign imm_i = {
        {(warp_pkg::DATA_WIDTH - 14){fetch_word.i_view.imm14[13]}},
        fetch_word.i_view.imm14
    };

    // upper immediate lives in bits 28..9
    assign imm_u = {
        fetch_word.i_view.spare,
        fetch_word.i_view.imm14,
        fetch_word.i_view.funct4,
        fetch_word.i_view.rs1[4]
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            // start every record from defaults
            dec_op.alu_op <= warp_pkg::ADD;
            dec_op.wb_sel <= warp_pkg::WB_ALU;
            dec_op.rd <= '0;
            dec_op.rs1 <= '0;
            dec_op.rs2 <= '0;
            dec_op.imm <= '0;
            dec_op.reg_write <= 1'b0;
            dec_op.halt <= 1'b0;
            dec_op.illegal <= 1'b0;

            case (fetch_word.r_view.opcode)
                warp_pkg::OPCODE_R: begin
                    dec_op.rd <= fetch_word.r_view.rd;
                    dec_op.rs1 <= fetch_word.r_view.rs1;
                    dec_op.rs2 <= fetch_word.r_view.rs2;
                    dec_op.reg_write <= 1'b1;

                    case (fetch_word.r_view.funct4)
                        warp_pkg::F4_ADD: dec_op.alu_op <= warp_pkg::ADD;
                        warp_pkg::F4_SUB: dec_op.alu_op <= warp_pkg::SUB;
                        warp_pkg::F4_MUL: dec_op.alu_op <= warp_pkg::MUL;
                        warp_pkg::F4_SLT: dec_op.alu_op <= warp_pkg::SLT;
                        warp_pkg::F4_SEQ: dec_op.alu_op <= warp_pkg::SEQ;
                        warp_pkg::F4_SNEZ: dec_op.alu_op <= warp_pkg::SNEZ;
                        warp_pkg::F4_MIN: dec_op.alu_op <= warp_pkg::MIN;
                        warp_pkg::F4_ABS: dec_op.alu_op <= warp_pkg::ABS;
                        warp_pkg::F4_SLL: dec_op.alu_op <= warp_pkg::SLL;
                        default: begin
                            dec_op.illegal <= 1'b1;
                            dec_op.reg_write <= 1'b0;
                        end
                    endcase
                end

                warp_pkg::OPCODE_I: begin
                    dec_op.rd <= fetch_word.i_view.rd;
                    dec_op.rs1 <= fetch_word.i_view.rs1;
                    dec_op.imm <= imm_i;
                    dec_op.reg_write <= 1'b1;

                    case (fetch_word.i_view.funct4)
                        warp_pkg::F4_ADDI: dec_op.alu_op <= warp_pkg::ADDI;
                        warp_pkg::F4_MULI: dec_op.alu_op <= warp_pkg::MULI;
                        warp_pkg::F4_SLLI: dec_op.alu_op <= warp_pkg::SLLI;
                        default: begin
                            dec_op.illegal <= 1'b1;
                            dec_op.reg_write <= 1'b0;
                        end
                    endcase
                end

                warp_pkg::OPCODE_UP: begin
                    // LUI
                    dec_op.rd <= fetch_word.i_view.rd;
                    dec_op.imm <= {imm_u, 12'b0};
                    dec_op.alu_op <= warp_pkg::PASS_IMM;
                    dec_op.wb_sel <= warp_pkg::WB_IMM;
                    dec_op.reg_write <= 1'b1;
                end

                warp_pkg::OPCODE_HALT: begin
                    dec_op.halt <= 1'b1;
                end

                default: begin
                    dec_op.illegal <= 1'b1;
                end
            endcase
        end
    end

    a_halt_xor_illegal: assert property (
        @(posedge clk) disable iff (reset) dec_valid |-> !(dec_op.illegal && dec_op.halt)
    ) else $error("decoded record marked both halt and illegal");

endmodule

`default_nettype wire

//--- rtl/instr_fetch.sv
`default_nettype none

module instr_fetch (
    input wire clk,
    input wire reset,
    input wire load_en,
    input wire [warp_pkg::PROG_ADDR_WIDTH-1:0] load_addr,
    input wire [warp_pkg::DATA_WIDTH-1:0] load_word,
    input wire start,
    input wire queue_almost_full,
    input wire halted,
    output logic fetch_valid,
    output logic [warp_pkg::DATA_WIDTH-1:0] fetch_word
);

    logic [warp_pkg::DATA_WIDTH-1:0] prog_mem [warp_pkg::PROG_DEPTH];

    // one extra bit so the counter can sit at the end of memory
    logic [warp_pkg::PROG_ADDR_WIDTH:0] pc;
    logic running;
    logic at_end;
    logic issue;

    assign at_end = (pc >= warp_pkg::PROG_DEPTH);
    assign issue = running && !halted && !queue_almost_full && !at_end;

    // program load port
    always_ff @(posedge clk) begin
        if (load_en) begin
            prog_mem[load_addr] <= load_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            pc <= '0;
        end else if (start) begin
            running <= 1'b1;
            pc <= '0;
        end else if (running && (halted || at_end)) begin
            running <= 1'b0;
        end else if (issue) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= issue;
        end
    end

    // word register, qualified by fetch_valid
    always_ff @(posedge clk) begin
        if (issue) begin
            fetch_word <= prog_mem[pc[warp_pkg::PROG_ADDR_WIDTH-1:0]];
        end
    end

    // memory must not change under a running program
    a_no_load_while_running: assert property (
        @(posedge clk) disable iff (reset) running |-> !load_en
    ) else $error("program load while fetch is running");

endmodule

`default_nettype wire

//--- rtl/mini_warp_top.sv
`default_nettype none

module mini_warp_top (
    input wire clk,
    input wire reset,
    input wire load_en,
    input wire [warp_pkg::PROG_ADDR_WIDTH-1:0] load_addr,
    input wire [warp_pkg::DATA_WIDTH-1:0] load_word,
    input wire start,
    output logic wb_valid,
    output warp_pkg::wb_t wb,
    output logic halted,
    output logic fault
);

    logic fetch_valid;
    logic [warp_pkg::DATA_WIDTH-1:0] fetch_word;
    logic dec_valid;
    warp_pkg::decoded_op_t dec_op;
    logic queue_empty;
    logic queue_almost_full;
    warp_pkg::decoded_op_t queue_head;
    logic pop;

    instr_fetch u_fetch (
        .clk(clk),
        .reset(reset),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_word(load_word),
        .start(start),
        .queue_almost_full(queue_almost_full),
        .halted(halted),
        .fetch_valid(fetch_valid),
        .fetch_word(fetch_word)
    );

    instr_decoder u_decoder (
        .clk(clk),
        .reset(reset),
        .fetch_valid(fetch_valid),
        .fetch_word(fetch_word),
        .dec_valid(dec_valid),
        .dec_op(dec_op)
    );

    decoded_queue u_queue (
        .clk(clk),
        .reset(reset),
        .push(dec_valid),
        .push_op(dec_op),
        .pop(pop),
        .queue_head(queue_head),
        .queue_empty(queue_empty),
        .queue_almost_full(queue_almost_full)
    );

    scalar_exec u_exec (
        .clk(clk),
        .reset(reset),
        .queue_empty(queue_empty),
        .queue_head(queue_head),
        .pop(pop),
        .wb_valid(wb_valid),
        .wb(wb),
        .halted(halted),
        .fault(fault)
    );

endmodule

`default_nettype wire

//--- rtl/scalar_exec.sv
`default_nettype none

module scalar_exec (
    input wire clk,
    input wire reset,
    input wire queue_empty,
    input wire warp_pkg::decoded_op_t queue_head,
    output logic pop,
    output logic wb_valid,
    output warp_pkg::wb_t wb,
    output logic halted,
    output logic fault
);

    logic [warp_pkg::DATA_WIDTH-1:0] reg_file [2 ** warp_pkg::REG_ADDR_WIDTH];

    logic [warp_pkg::DATA_WIDTH-1:0] rs1_data;
    logic [warp_pkg::DATA_WIDTH-1:0] rs2_data;
    logic [warp_pkg::DATA_WIDTH-1:0] alu_result;
    logic [warp_pkg::DATA_WIDTH-1:0] wb_data;
    logic is_mul;
    logic stop_op;
    logic single_wr;
    logic mul_wr;

    // multiply delay line, stage 0 holds the product
    warp_pkg::wb_t mul_pipe [warp_pkg::MUL_LATENCY-1];
    logic [warp_pkg::MUL_LATENCY-2:0] mul_valid;
    logic mul_busy;

    // x0 reads as zero
    assign rs1_data = (queue_head.rs1 == '0) ? '0 : reg_file[queue_head.rs1];
    assign rs2_data = (queue_head.rs2 == '0) ? '0 : reg_file[queue_head.rs2];

    always_comb begin
        case (queue_head.alu_op)
            warp_pkg::ADD: alu_result = rs1_data + rs2_data;
            warp_pkg::SUB: alu_result = rs1_data - rs2_data;
            warp_pkg::MUL: alu_result = rs1_data * rs2_data;
            warp_pkg::SLT: alu_result = {31'b0, $signed(rs1_data) < $signed(rs2_data)};
            warp_pkg::SEQ: alu_result = {31'b0, rs1_data == rs2_data};
            warp_pkg::SNEZ: alu_result = {31'b0, rs1_data != '0};
            warp_pkg::MIN: begin
                alu_result = ($signed(rs1_data) < $signed(rs2_data)) ? rs1_data : rs2_data;
            end
            warp_pkg::ABS: alu_result = rs1_data[31] ? (~rs1_data + 1'b1) : rs1_data;
            warp_pkg::SLL: alu_result = rs1_data << rs2_data[4:0];
            warp_pkg::ADDI: alu_result = rs1_data + queue_head.imm;
            warp_pkg::MULI: alu_result = rs1_data * queue_head.imm;
            warp_pkg::SLLI: alu_result = rs1_data << queue_head.imm[4:0];
            warp_pkg::PASS_IMM: alu_result = queue_head.imm;
            default: alu_result = '0;
        endcase
    end

    assign wb_data = (queue_head.wb_sel == warp_pkg::WB_IMM) ? queue_head.imm : alu_result;
    assign is_mul = (queue_head.alu_op == warp_pkg::MUL) || (queue_head.alu_op == warp_pkg::MULI);
    assign stop_op = queue_head.halt || queue_head.illegal;

    assign mul_busy = |mul_valid;
    assign pop = !queue_empty && !halted && !mul_busy;

    assign single_wr = pop && !stop_op && !is_mul && queue_head.reg_write
        && (queue_head.rd != '0);
    assign mul_wr = mul_valid[warp_pkg::MUL_LATENCY-2]
        && (mul_pipe[warp_pkg::MUL_LATENCY-2].rd != '0);

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
            fault <= 1'b0;
            wb_valid <= 1'b0;
            mul_valid <= '0;
        end else begin
            wb_valid <= single_wr || mul_wr;
            mul_valid[0] <= pop && !stop_op && is_mul;
            for (int i = 1; i < warp_pkg::MUL_LATENCY - 1; i++) begin
                mul_valid[i] <= mul_valid[i-1];
            end
            if (pop && stop_op) begin
                halted <= 1'b1;
                fault <= queue_head.illegal;
            end
        end
    end

    // register file, writeback and multiply payload
    always_ff @(posedge clk) begin
        mul_pipe[0].rd <= queue_head.rd;
        mul_pipe[0].data <= alu_result;
        for (int i = 1; i < warp_pkg::MUL_LATENCY - 1; i++) begin
            mul_pipe[i] <= mul_pipe[i-1];
        end

        if (single_wr) begin
            reg_file[queue_head.rd] <= wb_data;
            wb.rd <= queue_head.rd;
            wb.data <= wb_data;
        end else if (mul_wr) begin
            reg_file[mul_pipe[warp_pkg::MUL_LATENCY-2].rd] <=
                mul_pipe[warp_pkg::MUL_LATENCY-2].data;
            wb <= mul_pipe[warp_pkg::MUL_LATENCY-2];
        end
    end

    // nothing older than the halt may still be in the multiplier
    a_no_wb_after_halt: assert property (
        @(posedge clk) disable iff (reset) halted |=> !wb_valid
    ) else $error("writeback after halt");

endmodule

`default_nettype wire

//--- rtl/warp_pkg.sv
`default_nettype none

package warp_pkg;

    // datapath and register file sizes
    localparam int DATA_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // program memory
    localparam int PROG_DEPTH = 64;
    localparam int PROG_ADDR_WIDTH = 6;

    // decoded-op queue, slack covers the fetch and decode stages in flight
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_WIDTH = 3;
    localparam int QUEUE_SLACK = 2;

    localparam int MUL_LATENCY = 3;

    // major opcodes, bits 31..29
    localparam logic [2:0] OPCODE_R = 3'd0;
    localparam logic [2:0] OPCODE_I = 3'd1;
    localparam logic [2:0] OPCODE_UP = 3'd2;
    localparam logic [2:0] OPCODE_HALT = 3'd7;

    // funct4 codes, R-type
    localparam logic [3:0] F4_ADD = 4'b0000;
    localparam logic [3:0] F4_SUB = 4'b0001;
    localparam logic [3:0] F4_MUL = 4'b0010;
    localparam logic [3:0] F4_SLT = 4'b0100;
    localparam logic [3:0] F4_SEQ = 4'b0110;
    localparam logic [3:0] F4_SNEZ = 4'b0111;
    localparam logic [3:0] F4_MIN = 4'b1000;
    localparam logic [3:0] F4_ABS = 4'b1001;
    localparam logic [3:0] F4_SLL = 4'b1010;

    // funct4 codes, I-type
    localparam logic [3:0] F4_ADDI = 4'b0000;
    localparam logic [3:0] F4_MULI = 4'b0010;
    localparam logic [3:0] F4_SLLI = 4'b1010;

    typedef enum logic [3:0] {
        ADD, SUB, MUL, SLT, SEQ, SNEZ, MIN, ABS, SLL, ADDI, MULI, SLLI, PASS_IMM
    } alu_op_t;

    typedef enum logic {
        WB_ALU,
        WB_IMM
    } wb_sel_t;

    typedef struct packed {
        logic [2:0] opcode;
        logic [9:0] spare;
        logic [4:0] rs2;
        logic [3:0] funct4;
        logic [4:0] rs1;
        logic [4:0] rd;
    } instr_r_t;

    // imm14 sits over the spare bits and rs2 of the R view
    typedef struct packed {
        logic [2:0] opcode;
        logic spare;
        logic [13:0] imm14;
        logic [3:0] funct4;
        logic [4:0] rs1;
        logic [4:0] rd;
    } instr_i_t;

    typedef union packed {
        instr_r_t r_view;
        instr_i_t i_view;
    } instr_word_u;

    typedef struct packed {
        alu_op_t alu_op;
        wb_sel_t wb_sel;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic [DATA_WIDTH-1:0] imm;
        logic reg_write;
        logic halt;
        logic illegal;
    } decoded_op_t;

    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [DATA_WIDTH-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

//--- verification/mini_warp_tb.sv
`default_nettype none

module mini_warp_tb;

    logic clk;
    logic reset;
    logic load_en;
    logic [warp_pkg::PROG_ADDR_WIDTH-1:0] load_addr;
    logic [warp_pkg::DATA_WIDTH-1:0] load_word;
    logic start;
    logic wb_valid;
    warp_pkg::wb_t wb;
    logic halted;
    logic fault;

    logic [31:0] prog [warp_pkg::PROG_DEPTH];
    int prog_len;
    warp_pkg::wb_t exp_q [$];
    logic exp_fault;
    string cur_test;
    int err_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int watch_cycles = 0;
    int watch_limit = 0;

    tb_clock_gen clock_gen (.clk(clk));

    mini_warp_top dut0 (
        .clk(clk),
        .reset(reset),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_word(load_word),
        .start(start),
        .wb_valid(wb_valid),
        .wb(wb),
        .halted(halted),
        .fault(fault)
    );

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %h actual %h",
                     cur_test, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic emit_r(input logic [3:0] f4, input int rd, input int rs1, input int rs2);
        emit({warp_pkg::OPCODE_R, 10'b0, rs2[4:0], f4, rs1[4:0], rd[4:0]});
    endtask

    task automatic emit_i(input logic [3:0] f4, input int rd, input int rs1, input int imm);
        emit({warp_pkg::OPCODE_I, 1'b0, imm[13:0], f4, rs1[4:0], rd[4:0]});
    endtask

    task automatic emit_lui(input int rd, input int imm20);
        emit({warp_pkg::OPCODE_UP, imm20[19:0], 4'b0, rd[4:0]});
    endtask

    task automatic emit_halt();
        emit({warp_pkg::OPCODE_HALT, 29'b0});
    endtask

    // interprets prog, fills exp_q and exp_fault, returns instructions executed
    function automatic int ref_model(input int len);
        logic [31:0] regs [32];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [4:0] rd;
        int n;
        n = 0;
        exp_fault = 1'b0;
        exp_q.delete();
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int pc = 0; pc < len; pc++) begin
            w = prog[pc];
            n++;
            rd = w[4:0];
            a = regs[w[9:5]];
            b = regs[w[18:14]];
            imm = {{18{w[27]}}, w[27:14]};
            res = '0;
            case (w[31:29])
                warp_pkg::OPCODE_R: begin
                    case (w[13:10])
                        warp_pkg::F4_ADD: res = a + b;
                        warp_pkg::F4_SUB: res = a - b;
                        warp_pkg::F4_MUL: res = a * b;
                        warp_pkg::F4_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        warp_pkg::F4_SEQ: res = (a == b) ? 32'd1 : 32'd0;
                        warp_pkg::F4_SNEZ: res = (a != 0) ? 32'd1 : 32'd0;
                        warp_pkg::F4_MIN: res = ($signed(a) < $signed(b)) ? a : b;
                        warp_pkg::F4_ABS: res = ($signed(a) < 0) ? (32'd0 - a) : a;
                        warp_pkg::F4_SLL: res = a << b[4:0];
                        default: begin
                            exp_fault = 1'b1;
                            return n;
                        end
                    endcase
                end
                warp_pkg::OPCODE_I: begin
                    case (w[13:10])
                        warp_pkg::F4_ADDI: res = a + imm;
                        warp_pkg::F4_MULI: res = a * imm;
                        warp_pkg::F4_SLLI: res = a << imm[4:0];
                        default: begin
                            exp_fault = 1'b1;
                            return n;
                        end
                    endcase
                end
                warp_pkg::OPCODE_UP: res = {w[28:9], 12'b0};
                warp_pkg::OPCODE_HALT: return n;
                default: begin
                    exp_fault = 1'b1;
                    return n;
                end
            endcase
            // x0 stays zero and never shows a writeback
            if (rd != 0) begin
                regs[rd] = res;
                exp_q.push_back({rd, res});
            end
        end
        return n;
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    // unused words become HALT tagged with their address
    task automatic load_program();
        for (int addr = 0; addr < warp_pkg::PROG_DEPTH; addr++) begin
            @(negedge clk);
            load_en = 1'b1;
            load_addr = addr[5:0];
            load_word = (addr < prog_len) ? prog[addr]
                : {warp_pkg::OPCODE_HALT, 23'b0, addr[5:0]};
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic run_test(input string name);
        int count;
        int errs_before;
        count = ref_model(prog_len);
        cur_test = name;
        errs_before = err_count;
        watch_limit = count * (warp_pkg::MUL_LATENCY + 4) + warp_pkg::PROG_DEPTH + 40;
        watch_cycles = 0;
        apply_reset();
        load_program();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!halted) begin
            @(negedge clk);
        end
        // room for a stray writeback to show up
        repeat (warp_pkg::MUL_LATENCY + 2) @(negedge clk);
        check("fault", 64'(exp_fault), 64'(fault));
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected writebacks never arrived", name, exp_q.size());
            err_count++;
        end
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, err_count - errs_before);
        end else begin
            $display("test %s ok, %0d instructions", name, count);
        end
    endtask

    task automatic build_random();
        int body;
        int rd;
        int rs1;
        int rs2;
        prog_len = 0;
        for (int r = 1; r < 8; r++) begin
            emit_i(warp_pkg::F4_ADDI, r, 0, $urandom_range(0, 16383));
        end
        body = $urandom_range(1, 52);
        for (int k = 0; k < body; k++) begin
            rd = $urandom_range(0, 7);
            rs1 = $urandom_range(0, 7);
            rs2 = $urandom_range(0, 7);
            case ($urandom_range(0, 12))
                0: emit_r(warp_pkg::F4_ADD, rd, rs1, rs2);
                1: emit_r(warp_pkg::F4_SUB, rd, rs1, rs2);
                2: emit_r(warp_pkg::F4_MUL, rd, rs1, rs2);
                3: emit_r(warp_pkg::F4_SLT, rd, rs1, rs2);
                4: emit_r(warp_pkg::F4_SEQ, rd, rs1, rs2);
                5: emit_r(warp_pkg::F4_SNEZ, rd, rs1, 0);
                6: emit_r(warp_pkg::F4_MIN, rd, rs1, rs2);
                7: emit_r(warp_pkg::F4_ABS, rd, rs1, 0);
                8: emit_r(warp_pkg::F4_SLL, rd, rs1, rs2);
                9: emit_i(warp_pkg::F4_ADDI, rd, rs1, $urandom_range(0, 16383));
                10: emit_i(warp_pkg::F4_MULI, rd, rs1, $urandom_range(0, 16383));
                11: emit_i(warp_pkg::F4_SLLI, rd, rs1, $urandom_range(0, 31));
                default: emit_lui(rd, $urandom_range(0, 20'hfffff));
            endcase
        end
        emit_halt();
    endtask

    // compare each writeback against the reference list
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: unexpected writeback to x%0d", cur_test, wb.rd);
                err_count++;
            end else begin
                check("wb", 64'(exp_q.pop_front()), 64'(wb));
            end
        end
    end

    initial begin : watchdog
        while (watch_limit == 0 || watch_cycles <= watch_limit) begin
            @(posedge clk);
            watch_cycles++;
        end
        $display("timeout in test %s, halted never seen after %0d cycles",
                 cur_test, watch_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_word = '0;
        start = 1'b0;
        prog_len = 0;
        void'($urandom(32'hfde5d51e));

        // seeded operands, some negative
        emit_i(warp_pkg::F4_ADDI, 1, 0, -37);
        emit_i(warp_pkg::F4_ADDI, 2, 0, 105);
        emit_i(warp_pkg::F4_ADDI, 3, 0, -5);
        emit_i(warp_pkg::F4_ADDI, 4, 0, 3);
        emit_r(warp_pkg::F4_ADD, 5, 1, 2);
        emit_r(warp_pkg::F4_SUB, 6, 1, 2);
        emit_r(warp_pkg::F4_SLT, 7, 1, 2);
        emit_r(warp_pkg::F4_SLT, 8, 2, 1);
        emit_r(warp_pkg::F4_SEQ, 9, 1, 1);
        emit_r(warp_pkg::F4_SEQ, 10, 1, 2);
        emit_r(warp_pkg::F4_SNEZ, 11, 3, 0);
        emit_r(warp_pkg::F4_SNEZ, 12, 0, 0);
        emit_r(warp_pkg::F4_MIN, 13, 1, 3);
        emit_r(warp_pkg::F4_MIN, 14, 2, 4);
        emit_r(warp_pkg::F4_ABS, 15, 1, 0);
        emit_r(warp_pkg::F4_ABS, 16, 2, 0);
        emit_r(warp_pkg::F4_SLL, 17, 3, 4);
        emit_halt();
        run_test("arith");

        prog_len = 0;
        emit_i(warp_pkg::F4_ADDI, 1, 0, -1);
        emit_i(warp_pkg::F4_ADDI, 2, 0, -8192);
        emit_i(warp_pkg::F4_ADDI, 3, 2, 8191);
        emit_i(warp_pkg::F4_SLLI, 4, 1, 31);
        emit_i(warp_pkg::F4_SLLI, 5, 2, 4);
        emit_lui(6, 20'habcde);
        emit_i(warp_pkg::F4_ADDI, 6, 6, 8191);
        emit_i(warp_pkg::F4_ADDI, 7, 6, -1);
        emit_lui(8, 20'h80000);
        emit_i(warp_pkg::F4_ADDI, 8, 8, -4);
        emit_halt();
        run_test("immediate");

        prog_len = 0;
        emit_i(warp_pkg::F4_ADDI, 0, 0, 55);
        emit_i(warp_pkg::F4_ADDI, 1, 0, 9);
        emit_r(warp_pkg::F4_ADD, 0, 1, 1);
        emit_r(warp_pkg::F4_MUL, 0, 1, 1);
        emit_r(warp_pkg::F4_ADD, 2, 0, 1);
        emit_r(warp_pkg::F4_SEQ, 3, 0, 0);
        emit_r(warp_pkg::F4_SNEZ, 4, 0, 0);
        emit_halt();
        run_test("x0");

        // dependent multiplies stall pops and fill the queue
        prog_len = 0;
        emit_i(warp_pkg::F4_ADDI, 1, 0, 3);
        emit_i(warp_pkg::F4_ADDI, 2, 0, -2);
        for (int k = 0; k < 42; k++) begin
            case (k % 3)
                0: emit_r(warp_pkg::F4_MUL, 1, 1, 2);
                1: emit_i(warp_pkg::F4_MULI, 2, 1, -3);
                default: emit_r(warp_pkg::F4_ADD, 3, 1, 2);
            endcase
        end
        emit_halt();
        run_test("backpress");

        prog_len = 0;
        emit_i(warp_pkg::F4_ADDI, 1, 0, 7);
        emit_r(warp_pkg::F4_ADD, 2, 1, 1);
        emit_r(4'b0011, 5, 1, 1);
        emit_i(warp_pkg::F4_ADDI, 3, 0, 1);
        emit_r(warp_pkg::F4_ADD, 4, 1, 1);
        emit_halt();
        run_test("illegal");

        for (int t = 0; t < 20; t++) begin
            build_random();
            run_test($sformatf("random%0d", t));
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // period of 4 time units
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

`default_nettype wire
